// ==== Bender.yml ====
package:
  name: saber_game

sources:
  # packages first, then leaf modules, then the top level
  - rtl/game_pkg.sv
  - rtl/pixel_pkg.sv
  - rtl/game_state.sv
  - rtl/block_tracker.sv
  - rtl/slice_detector.sv
  - rtl/pixel_block_selector.sv
  - rtl/pixel_shader.sv
  - rtl/saber_game_top.sv
  - target: simulation
    files:
      - tb/saber_game_tb.sv

// ==== rtl/block_tracker.sv ====
module block_tracker import game_pkg::*; (
    input  logic        clk_in,
    input  logic        rst_in,
    input  game_time_t  curr_time,
    output depth_t      block_z [NUM_BLOCKS],
    output block_mask_t visible_mask,
    output block_mask_t passed_mask
);

    // ticks left until each block arrives
    game_time_t  ticks_left [NUM_BLOCKS];
    block_mask_t passed_now;
    block_mask_t visible_now;

    always_comb begin
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            ticks_left[i]  = SCHED_TIME[i] - curr_time;
            // past arrival, so remaining would go negative
            passed_now[i]  = (curr_time > SCHED_TIME[i]);
            visible_now[i] = !passed_now[i] && (ticks_left[i] < VIEW_TICKS);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // registered outputs

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            visible_mask <= '0;
            passed_mask  <= '0;
        end else begin
            visible_mask <= visible_now;
            passed_mask  <= passed_now;
        end
    end

    // depth scales linearly with remaining ticks
    always_ff @(posedge clk_in) begin
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            block_z[i] <= depth_t'(ticks_left[i] * Z_PER_TICK);
        end
    end

endmodule

// ==== rtl/game_pkg.sv ====
package game_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // gameplay types

    typedef logic [11:0] coord_t;
    typedef logic [13:0] depth_t;
    typedef logic [17:0] game_time_t;
    typedef logic [2:0]  block_idx_t;
    typedef logic [7:0]  block_mask_t;
    typedef logic [3:0]  health_t;
    typedef logic [11:0] score_t;
    typedef logic [2:0]  combo_t;

    // play-state machine encoding
    typedef enum logic [1:0] {
        ST_READY,
        ST_PLAYING,
        ST_DEAD,
        ST_DONE
    } play_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // gameplay constants

    localparam int NUM_BLOCKS = 8;
    // clocks per game tick
    localparam int TICKS_DIV  = 16;
    // depth step per tick
    localparam int Z_PER_TICK = 8;
    // ticks a block is on screen before arrival
    localparam int VIEW_TICKS = 40;
    // slice window in depth
    localparam int HIT_DEPTH  = 64;
    localparam int BLOCK_HALF = 32;
    localparam int MAX_HEALTH = 4;
    localparam int MAX_COMBO  = 7;
    localparam int END_TIME   = 240;

    // fixed block schedule, squares kept below the hud and inside 512x384
    localparam coord_t SCHED_X [NUM_BLOCKS] = '{
        12'd96, 12'd416, 12'd256, 12'd128, 12'd384, 12'd200, 12'd320, 12'd256
    };
    localparam coord_t SCHED_Y [NUM_BLOCKS] = '{
        12'd120, 12'd200, 12'd300, 12'd280, 12'd96, 12'd180, 12'd320, 12'd140
    };
    // arrival tick, strictly increasing
    localparam game_time_t SCHED_TIME [NUM_BLOCKS] = '{
        18'd50, 18'd70, 18'd90, 18'd110, 18'd130, 18'd150, 18'd175, 18'd200
    };
    // 1 red, 0 blue
    localparam logic SCHED_COLOR [NUM_BLOCKS] = '{
        1'b1, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1
    };

endpackage

// ==== rtl/game_state.sv ====
module game_state import game_pkg::*; (
    input  logic        clk_in,
    input  logic        rst_in,
    input  logic        start,
    input  logic        slice_valid,
    input  block_idx_t  slice_idx,
    input  logic        miss_valid,
    input  block_idx_t  miss_idx,
    output play_state_t play_state,
    output game_time_t  curr_time,
    output health_t     health,
    output score_t      score,
    output combo_t      combo,
    output block_mask_t sliced_mask,
    output block_mask_t resolved_mask
);

    // tick divider
    logic [$clog2(TICKS_DIV)-1:0] div_cnt;
    logic        tick;
    logic        playing;
    logic        slice_ok;
    logic        miss_ok;
    play_state_t state_next;
    health_t     health_next;
    score_t      score_next;
    combo_t      combo_next;
    block_mask_t sliced_next;
    block_mask_t resolved_next;

    assign playing = (play_state == ST_PLAYING);
    assign tick    = playing && (div_cnt == TICKS_DIV - 1);

    // events count only while playing, and once per block
    assign slice_ok = playing && slice_valid && !resolved_mask[slice_idx];
    assign miss_ok  = playing && miss_valid && !resolved_mask[miss_idx];

    ////////////////////////////////////////////////////////////////////////////
    // rule update

    always_comb begin
        health_next   = health;
        score_next    = score;
        combo_next    = combo;
        sliced_next   = sliced_mask;
        resolved_next = resolved_mask;
        if (slice_ok) begin
            score_next             = score + score_t'(combo) + 1'b1;
            // combo saturates
            combo_next             = (combo == MAX_COMBO) ? combo : combo + 1'b1;
            sliced_next[slice_idx]   = 1'b1;
            resolved_next[slice_idx] = 1'b1;
        end
        // miss last so a same-cycle miss wins the combo
        if (miss_ok) begin
            health_next             = health - 1'b1;
            combo_next              = '0;
            resolved_next[miss_idx] = 1'b1;
        end
    end

    // play-state transitions
    always_comb begin
        state_next = play_state;
        case (play_state)
            ST_READY: begin
                if (start) begin
                    state_next = ST_PLAYING;
                end
            end
            ST_PLAYING: begin
                if (health_next == 0) begin
                    state_next = ST_DEAD;
                end else if (curr_time == END_TIME) begin
                    state_next = ST_DONE;
                end
            end
            // dead and done held until reset
            default: state_next = play_state;
        endcase
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            play_state    <= ST_READY;
            div_cnt       <= '0;
            curr_time     <= '0;
            health        <= health_t'(MAX_HEALTH);
            score         <= '0;
            combo         <= '0;
            sliced_mask   <= '0;
            resolved_mask <= '0;
        end else begin
            play_state    <= state_next;
            health        <= health_next;
            score         <= score_next;
            combo         <= combo_next;
            sliced_mask   <= sliced_next;
            resolved_mask <= resolved_next;
            if (tick) begin
                div_cnt   <= '0;
                curr_time <= curr_time + 1'b1;
            end else if (playing) begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/pixel_block_selector.sv ====
module pixel_block_selector import game_pkg::*, pixel_pkg::*; (
    input  logic        clk_in,
    input  logic        rst_in,
    input  logic        pixel_valid,
    input  pix_x_t      pixel_x,
    input  pix_y_t      pixel_y,
    input  depth_t      block_z [NUM_BLOCKS],
    input  block_mask_t visible_mask,
    input  block_mask_t sliced_mask,
    output logic        sel_valid,
    output pix_x_t      sel_x,
    output pix_y_t      sel_y,
    output logic        sel_hit,
    output logic        sel_color
);

    // stage 1 registers
    logic        s1_valid;
    pix_x_t      s1_x;
    pix_y_t      s1_y;
    block_mask_t s1_cover;
    block_mask_t cover_now;
    // stage 2 scan
    logic        best_hit;
    depth_t      best_z;
    logic        best_color;

    // pixel inside the square on one axis
    function automatic logic in_square(int p, coord_t c);
        return (p + BLOCK_HALF >= int'(c)) && (p < int'(c) + BLOCK_HALF);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // stage 1, coverage

    always_comb begin
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            cover_now[i] = visible_mask[i] && !sliced_mask[i] &&
                           in_square(int'(pixel_x), SCHED_X[i]) &&
                           in_square(int'(pixel_y), SCHED_Y[i]);
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= pixel_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        s1_x     <= pixel_x;
        s1_y     <= pixel_y;
        s1_cover <= cover_now;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stage 2, nearest covering block

    // strict compare keeps ties on the lower index
    always_comb begin
        best_hit   = 1'b0;
        best_z     = '1;
        best_color = 1'b0;
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            if (s1_cover[i] && (!best_hit || block_z[i] < best_z)) begin
                best_hit   = 1'b1;
                best_z     = block_z[i];
                best_color = SCHED_COLOR[i];
            end
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            sel_valid <= 1'b0;
        end else begin
            sel_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk_in) begin
        sel_x     <= s1_x;
        sel_y     <= s1_y;
        sel_hit   <= best_hit;
        sel_color <= best_color;
    end

endmodule

// ==== rtl/pixel_pkg.sv ====
package pixel_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // screen side types

    typedef logic [10:0] pix_x_t;
    typedef logic [9:0]  pix_y_t;
    typedef logic [3:0]  channel_t;

    // health bar geometry
    localparam int HUD_ROWS  = 16;
    // bar width per health point
    localparam int HUD_SEG_W = 32;

    ////////////////////////////////////////////////////////////////////////////
    // palette, packed as {r, g, b}

    localparam logic [11:0] COLOR_RED  = {4'hF, 4'h0, 4'h0};
    localparam logic [11:0] COLOR_BLUE = {4'h0, 4'h0, 4'hF};
    localparam logic [11:0] COLOR_BAR  = {4'h0, 4'hF, 4'h0};
    // dim gray behind the bar
    localparam logic [11:0] COLOR_HUD  = {4'h2, 4'h2, 4'h2};
    localparam logic [11:0] COLOR_BG   = {4'h0, 4'h0, 4'h0};

endpackage

// ==== rtl/pixel_shader.sv ====
module pixel_shader import game_pkg::*, pixel_pkg::*; (
    input  logic     clk_in,
    input  logic     rst_in,
    input  health_t  health,
    input  logic     sel_valid,
    input  pix_x_t   sel_x,
    input  pix_y_t   sel_y,
    input  logic     sel_hit,
    input  logic     sel_color,
    output logic     rgb_valid,
    output pix_x_t   rgb_x,
    output pix_y_t   rgb_y,
    output channel_t r_out,
    output channel_t g_out,
    output channel_t b_out
);

    // bar length in pixels
    pix_x_t      bar_w;
    logic [11:0] color;

    assign bar_w = pix_x_t'(health * HUD_SEG_W);

    // hud first, then block, then background
    always_comb begin
        if (sel_y < HUD_ROWS) begin
            color = (sel_x < bar_w) ? COLOR_BAR : COLOR_HUD;
        end else if (sel_hit) begin
            color = sel_color ? COLOR_RED : COLOR_BLUE;
        end else begin
            color = COLOR_BG;
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            rgb_valid <= 1'b0;
        end else begin
            rgb_valid <= sel_valid;
        end
    end

    // unpack {r, g, b}
    always_ff @(posedge clk_in) begin
        rgb_x <= sel_x;
        rgb_y <= sel_y;
        r_out <= color[11:8];
        g_out <= color[7:4];
        b_out <= color[3:0];
    end

endmodule

// ==== rtl/saber_game_top.sv ====
module saber_game_top import game_pkg::*, pixel_pkg::*; (
    input  logic        clk_in,
    input  logic        rst_in,
    input  logic        start,
    input  coord_t      hand_x,
    input  coord_t      hand_y,
    input  logic        pixel_valid,
    input  pix_x_t      pixel_x,
    input  pix_y_t      pixel_y,
    output play_state_t play_state,
    output health_t     health,
    output score_t      score,
    output combo_t      combo,
    output logic        rgb_valid,
    output pix_x_t      rgb_x,
    output pix_y_t      rgb_y,
    output channel_t    r_out,
    output channel_t    g_out,
    output channel_t    b_out
);

    ////////////////////////////////////////////////////////////////////////////
    // game side wires

    game_time_t  curr_time;
    block_mask_t sliced_mask;
    block_mask_t resolved_mask;
    depth_t      block_z [NUM_BLOCKS];
    block_mask_t visible_mask;
    block_mask_t passed_mask;
    logic        slice_valid;
    block_idx_t  slice_idx;
    logic        miss_valid;
    block_idx_t  miss_idx;

    // selector to shader
    logic        sel_valid;
    pix_x_t      sel_x;
    pix_y_t      sel_y;
    logic        sel_hit;
    logic        sel_color;

    game_state game_state_i (
        .clk_in, .rst_in, .start,
        .slice_valid, .slice_idx, .miss_valid, .miss_idx,
        .play_state, .curr_time, .health, .score, .combo,
        .sliced_mask, .resolved_mask
    );

    // positions follow game time
    block_tracker block_tracker_i (
        .clk_in, .rst_in, .curr_time,
        .block_z, .visible_mask, .passed_mask
    );

    slice_detector slice_detector_i (
        .clk_in, .rst_in, .hand_x, .hand_y,
        .block_z, .visible_mask, .passed_mask, .resolved_mask,
        .slice_valid, .slice_idx, .miss_valid, .miss_idx
    );

    ////////////////////////////////////////////////////////////////////////////
    // pixel path, three cycles

    pixel_block_selector pixel_block_selector_i (
        .clk_in, .rst_in, .pixel_valid, .pixel_x, .pixel_y,
        .block_z, .visible_mask, .sliced_mask,
        .sel_valid, .sel_x, .sel_y, .sel_hit, .sel_color
    );

    pixel_shader pixel_shader_i (
        .clk_in, .rst_in, .health,
        .sel_valid, .sel_x, .sel_y, .sel_hit, .sel_color,
        .rgb_valid, .rgb_x, .rgb_y, .r_out, .g_out, .b_out
    );

endmodule

// ==== rtl/slice_detector.sv ====
module slice_detector import game_pkg::*; (
    input  logic        clk_in,
    input  logic        rst_in,
    input  coord_t      hand_x,
    input  coord_t      hand_y,
    input  depth_t      block_z [NUM_BLOCKS],
    input  block_mask_t visible_mask,
    input  block_mask_t passed_mask,
    input  block_mask_t resolved_mask,
    output logic        slice_valid,
    output block_idx_t  slice_idx,
    output logic        miss_valid,
    output block_idx_t  miss_idx
);

    block_mask_t slice_cand;
    block_mask_t miss_cand;

    // saber within half a block of the center on one axis
    function automatic logic near_center(coord_t p, coord_t c);
        return (int'(p) + BLOCK_HALF >= int'(c)) && (int'(p) <= int'(c) + BLOCK_HALF);
    endfunction

    // lowest set index
    function automatic block_idx_t first_set(block_mask_t m);
        block_idx_t idx;
        idx = '0;
        for (int i = NUM_BLOCKS - 1; i >= 0; i--) begin
            if (m[i]) begin
                idx = block_idx_t'(i);
            end
        end
        return idx;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // candidates

    always_comb begin
        for (int i = 0; i < NUM_BLOCKS; i++) begin
            // close in depth and under the saber
            slice_cand[i] = visible_mask[i] && !resolved_mask[i] &&
                            (block_z[i] <= HIT_DEPTH) &&
                            near_center(hand_x, SCHED_X[i]) &&
                            near_center(hand_y, SCHED_Y[i]);
            miss_cand[i]  = passed_mask[i] && !resolved_mask[i];
        end
    end

    always_ff @(posedge clk_in) begin
        if (rst_in) begin
            slice_valid <= 1'b0;
            miss_valid  <= 1'b0;
        end else begin
            slice_valid <= |slice_cand;
            miss_valid  <= |miss_cand;
        end
    end

    // index only meaningful with its valid
    always_ff @(posedge clk_in) begin
        slice_idx <= first_set(slice_cand);
        miss_idx  <= first_set(miss_cand);
    end

endmodule

// ==== sim.f ====
rtl/game_pkg.sv
rtl/pixel_pkg.sv
rtl/game_state.sv
rtl/block_tracker.sv
rtl/slice_detector.sv
rtl/pixel_block_selector.sv
rtl/pixel_shader.sv
rtl/saber_game_top.sv
tb/saber_game_tb.sv

// ==== tb/saber_game_tb.sv ====
module saber_game_tb import game_pkg::*, pixel_pkg::*; ();

    // two games run about 2 * END_TIME * TICKS_DIV clocks, wide margin on top
    localparam int TIMEOUT_CYCLES = 20000;

    logic        clk_in = 1'b0;
    logic        rst_in = 1'b1;
    logic        start = 1'b0;
    coord_t      hand_x = '1;
    coord_t      hand_y = '1;
    logic        pixel_valid = 1'b0;
    pix_x_t      pixel_x = '0;
    pix_y_t      pixel_y = '0;
    play_state_t play_state;
    health_t     health;
    score_t      score;
    combo_t      combo;
    logic        rgb_valid;
    pix_x_t      rgb_x;
    pix_y_t      rgb_y;
    channel_t    r_out;
    channel_t    g_out;
    channel_t    b_out;

    // pixel requests seen at the last three rising edges, index 2 oldest
    logic        hist_valid [3] = '{1'b0, 1'b0, 1'b0};
    pix_x_t      hist_x [3];
    pix_y_t      hist_y [3];
    logic        rst_seen = 1'b1;
    logic [31:0] lcg_state = 32'ha76d;
    int          cycle_count = 0;
    // game outputs as they stood one cycle back
    play_state_t prev_state = ST_READY;
    health_t     prev_health = health_t'(MAX_HEALTH);
    score_t      prev_score = '0;
    combo_t      prev_combo = '0;
    int          exp_score;
    int          exp_combo;

    saber_game_top saber_game_top_i (.*);

    always #50 clk_in = ~clk_in;

    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // inclusive on both edges, so boundary pixels may go either way
    function automatic logic covers(int p, int c);
        return (p + BLOCK_HALF >= c) && (p <= c + BLOCK_HALF);
    endfunction

    task automatic report_mismatch(input string name, input int expected, input int actual);
        $display("FAIL time=%0t signal=%s expected=%0d (0x%0h) actual=%0d (0x%0h)",
                 $time, name, expected, expected, actual, actual);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic abort_with(input string reason);
        $display("error at time %0t: %s", $time, reason);
        $display("Testbench failed");
        $fatal(1);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // color rules against the schedule

    task automatic check_color(input int px, input int py, input int hp);
        logic [11:0] rgb;
        logic [11:0] bar_exp;
        logic        covered;
        logic        matched;
        rgb = {r_out, g_out, b_out};
        if (py < HUD_ROWS) begin
            // bar grows one segment per health point
            bar_exp = (px < hp * HUD_SEG_W) ? COLOR_BAR : COLOR_HUD;
            assert (rgb == bar_exp) else report_mismatch("hud rgb", bar_exp, rgb);
        end else begin
            covered = 1'b0;
            matched = (rgb == COLOR_BG);
            for (int i = 0; i < NUM_BLOCKS; i++) begin
                if (covers(px, SCHED_X[i]) && covers(py, SCHED_Y[i])) begin
                    covered = 1'b1;
                    if (rgb == (SCHED_COLOR[i] ? COLOR_RED : COLOR_BLUE)) begin
                        matched = 1'b1;
                    end
                end
            end
            if (!covered) begin
                assert (rgb == COLOR_BG) else report_mismatch("background rgb", COLOR_BG, rgb);
            end else begin
                assert (matched) else report_mismatch("block rgb", COLOR_BG, rgb);
            end
        end
    endtask

    task automatic wait_for_change();
        score_t  score_was;
        health_t health_was;
        score_was  = score;
        health_was = health;
        do begin
            @(negedge clk_in);
        end while (score == score_was && health == health_was);
    endtask

    task automatic wait_until_over();
        while (play_state == ST_READY || play_state == ST_PLAYING) begin
            @(negedge clk_in);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // edge sampling and watchdog

    // inputs are stable at the rising edge
    always @(posedge clk_in) begin
        rst_seen = rst_in;
        if (rst_in) begin
            for (int i = 0; i < 3; i++) begin
                hist_valid[i] = 1'b0;
            end
        end else begin
            for (int i = 2; i > 0; i--) begin
                hist_valid[i] = hist_valid[i-1];
                hist_x[i]     = hist_x[i-1];
                hist_y[i]     = hist_y[i-1];
            end
            hist_valid[0] = pixel_valid;
            hist_x[0]     = pixel_x;
            hist_y[0]     = pixel_y;
        end
    end

    always @(posedge clk_in) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout, the games did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Testbench failed");
            $fatal(1);
        end
    end

    // random pixel requests
    always @(negedge clk_in) begin
        lcg_state   = lcg_next(lcg_state);
        pixel_valid = lcg_state[12];
        pixel_x     = pix_x_t'(lcg_state[31:23]);
        pixel_y     = pix_y_t'(lcg_state[22:13] % 384);
    end

    ////////////////////////////////////////////////////////////////////////////
    // output monitor, outputs settled by the falling edge

    always @(negedge clk_in) begin
        if (rst_seen) begin
            assert (play_state == ST_READY)
                else report_mismatch("play_state", ST_READY, play_state);
            assert (health == MAX_HEALTH) else report_mismatch("health", MAX_HEALTH, health);
            assert (score == 0) else report_mismatch("score", 0, score);
            assert (combo == 0) else report_mismatch("combo", 0, combo);
            assert (rgb_valid == 1'b0) else report_mismatch("rgb_valid", 0, rgb_valid);
        end else begin
            // forward only, terminal states held
            assert (play_state == prev_state ||
                    (prev_state == ST_READY && play_state == ST_PLAYING) ||
                    (prev_state == ST_PLAYING &&
                     (play_state == ST_DEAD || play_state == ST_DONE)))
                else report_mismatch("play_state", prev_state, play_state);
            assert ((health == 0) == (play_state == ST_DEAD))
                else abort_with("play state ST_DEAD does not agree with health of zero");
            if (score != prev_score) begin
                exp_score = int'(prev_score) + int'(prev_combo) + 1;
                assert (int'(score) == exp_score) else report_mismatch("score", exp_score, score);
                if (health == prev_health) begin
                    // one more than before, capped
                    exp_combo = int'(prev_combo) + 1;
                    if (exp_combo > MAX_COMBO) begin
                        exp_combo = MAX_COMBO;
                    end
                    assert (combo == exp_combo) else report_mismatch("combo", exp_combo, combo);
                end
            end
            if (health != prev_health) begin
                assert (int'(health) == int'(prev_health) - 1)
                    else report_mismatch("health", int'(prev_health) - 1, health);
                assert (combo == 0) else report_mismatch("combo", 0, combo);
            end
            // no event, no combo change
            if (score == prev_score && health == prev_health) begin
                assert (combo == prev_combo) else report_mismatch("combo", prev_combo, combo);
            end
        end
        // three cycle pixel latency
        assert (rgb_valid == hist_valid[2])
            else report_mismatch("rgb_valid", hist_valid[2], rgb_valid);
        if (hist_valid[2]) begin
            assert (rgb_x == hist_x[2]) else report_mismatch("rgb_x", hist_x[2], rgb_x);
            assert (rgb_y == hist_y[2]) else report_mismatch("rgb_y", hist_y[2], rgb_y);
            // shader saw health from before the last edge
            check_color(hist_x[2], hist_y[2], prev_health);
        end
        prev_state  = play_state;
        prev_health = health;
        prev_score  = score;
        prev_combo  = combo;
    end

    ////////////////////////////////////////////////////////////////////////////
    // two games

    initial begin
        int total_exp;
        int run_combo;
        int start_cycle;
        total_exp = 0;
        run_combo = 0;
        for (int k = 0; k < NUM_BLOCKS; k++) begin
            total_exp = total_exp + 1 + run_combo;
            run_combo = (run_combo == MAX_COMBO) ? MAX_COMBO : run_combo + 1;
        end
        repeat (2) @(negedge clk_in);
        rst_in = 1'b0;
        // game 1, saber chases each block in turn
        hand_x = SCHED_X[0];
        hand_y = SCHED_Y[0];
        @(negedge clk_in);
        start = 1'b1;
        @(negedge clk_in);
        start = 1'b0;
        for (int k = 0; k < NUM_BLOCKS; k++) begin
            hand_x = SCHED_X[k];
            hand_y = SCHED_Y[k];
            wait_for_change();
        end
        wait_until_over();
        assert (play_state == ST_DONE) else report_mismatch("play_state", ST_DONE, play_state);
        assert (int'(score) == total_exp) else report_mismatch("score", total_exp, score);
        // game 2, saber off screen so every block is missed
        rst_in = 1'b1;
        hand_x = '1;
        hand_y = '1;
        repeat (2) @(negedge clk_in);
        rst_in = 1'b0;
        @(negedge clk_in);
        start = 1'b1;
        @(negedge clk_in);
        start = 1'b0;
        start_cycle = cycle_count;
        wait_until_over();
        assert (play_state == ST_DEAD) else report_mismatch("play_state", ST_DEAD, play_state);
        assert (cycle_count - start_cycle <= END_TIME * TICKS_DIV)
            else abort_with("health did not run out within END_TIME ticks");
        $display("Testbench passed");
        $finish;
    end

endmodule
